// File: flist.f
rtl/fwft_fifo_pkg.sv
rtl/fifo_ctrl.sv
rtl/fifo_ram.sv
rtl/fifo_fwft.sv
rtl/fwft_fifo_top.sv
bench/clk_gen.sv
bench/fwft_fifo_sva.sv
bench/tb_fwft_fifo.sv

// File: run_sim.sh
#!/bin/sh
# build the FWFT FIFO testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fwft_fifo \
   -f flist.f -o sim_fwft_fifo || exit 1
out=$(./obj_dir/sim_fwft_fifo 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && echo "run ok" || { echo "run failed"; exit 1; }

// File: bench/tb_fwft_fifo.sv
/*
  testbench for the single-clock FWFT FIFO
  inputs change 1 ns after the rising edge, the scoreboard samples at the falling edge
  cycle timing and flags are checked by the bound assertion module
*/

`timescale 1ns/10ps

module tb_fwft_fifo import fwft_fifo_pkg::*; ();

   logic  pos_rclk;
   logic  aresetn_rclk;
   logic  wr_en;
   logic  rd_en;
   data_t din;
   data_t dout;
   logic  full;
   logic  afull;
   logic  empty;
   logic  aempty;
   data_t ref_q [$];
   int    cycles;

   clk_gen u_clk (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk)
   );

   fwft_fifo_top dut (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .wr_en        (wr_en),
      .din          (din),
      .rd_en        (rd_en),
      .dout         (dout),
      .full         (full),
      .afull        (afull),
      .empty        (empty),
      .aempty       (aempty)
   );

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Simulation FAILED");
      $fatal(1, "first error, run stopped");
   endtask

   // one drive point, then on to the next one
   task automatic step(input logic w, input logic r);
      wr_en = w;
      rd_en = r;
      din   = data_t'($urandom);
      @(posedge pos_rclk);
      #1;
   endtask

   function automatic logic pick_60pct();
      return (($urandom % 100) < 60);
   endfunction

   // ---------------------------------------------------------------------
   // scoreboard, ports are stable mid cycle
   // ---------------------------------------------------------------------
   always @(negedge pos_rclk) begin
      if (aresetn_rclk) begin
         // full counts memory words only, so the queue has at least DEPTH
         assert (!full || ref_q.size() >= DEPTH) else
            stop_on_error($sformatf("full high with only %0d words written", ref_q.size()));
         if (rd_en && !empty) begin
            assert (ref_q.size() > 0) else
               stop_on_error("read acknowledged while no word was waiting");
            assert (dout == ref_q[0]) else
               stop_on_error($sformatf("** Error: dout = %h, expected %h", dout, ref_q[0]));
            void'(ref_q.pop_front());
         end
         // dropped writes never enter the queue
         if (wr_en && !full) begin
            ref_q.push_back(din);
         end
      end
   end

   // about 700 cycles of stimulus, limit leaves wide margin
   always @(posedge pos_rclk) begin
      cycles = cycles + 1;
      if (cycles > 4000) begin
         stop_on_error("timeout, run went past 4000 cycles");
      end
   end

   // ---------------------------------------------------------------------
   // stimulus
   // ---------------------------------------------------------------------
   initial begin
      void'($urandom(32'h78b8));
      wr_en  = 1'b0;
      rd_en  = 1'b0;
      din    = '0;
      cycles = 0;
      @(posedge aresetn_rclk);

      // state left by reset
      assert (empty && aempty && !full && !afull) else
         stop_on_error($sformatf("** Error: empty = %h aempty = %h full = %h afull = %h",
                                 empty, aempty, full, afull));
      assert (dout == '0) else
         stop_on_error($sformatf("** Error: dout = %h, expected %h", dout, 16'h0));

      // burst fill, then a few writes that must be dropped
      while (!full) begin
         step(1'b1, 1'b0);
      end
      repeat (4) step(1'b1, 1'b0);

      // drain, then reads on an empty FIFO
      while (ref_q.size() != 0) begin
         step(1'b0, 1'b1);
      end
      repeat (4) step(1'b0, 1'b1);

      // mixed traffic
      repeat (600) step(pick_60pct(), pick_60pct());

      // final drain
      while (ref_q.size() != 0) begin
         step(1'b0, 1'b1);
      end
      step(1'b0, 1'b0);

      if (ref_q.size() == 0 && empty) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         stop_on_error("FIFO not empty after the final drain");
      end
   end

endmodule

// File: bench/fwft_fifo_sva.sv
/*
  timing and flag checks, bound into fwft_fifo_top
  keeps its own count of words held, memory plus the three FWFT registers
  samples on the rising edge, all checks off during reset
*/

`timescale 1ns/10ps

module fwft_fifo_sva import fwft_fifo_pkg::*; (
   input logic  pos_rclk,
   input logic  aresetn_rclk,
   input logic  wr_en,
   input data_t din,
   input logic  rd_en,
   input data_t dout,
   input logic  full,
   input logic  afull,
   input logic  empty,
   input logic  aempty
);

   int   held;
   logic wr_ok;
   logic rd_ok;
   logic first_wr;
   logic idle_rd;

   assign wr_ok = wr_en & ~full;
   assign rd_ok = rd_en & ~empty;
   // write into a FIFO with nothing anywhere
   assign first_wr = wr_ok & (held == 0);
   // read attempt with nothing anywhere
   assign idle_rd = rd_en & empty & (held == 0);

   // words accepted minus words popped
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         held <= 0;
      end else begin
         held <= held + int'(wr_ok) - int'(rd_ok);
      end
   end

   // ---------------------------------------------------------------------
   // data timing
   // ---------------------------------------------------------------------
   // first word on dout after the second edge following its write
   a_first_word: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      $past(first_wr, 3) |-> (!empty && dout == $past(din, 3)))
      else $error("first word late or wrong, empty = %h dout = %h", empty, dout);

   // no pop, so head word and empty stay put
   a_hold: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      $past(!rd_en && !empty) |-> (!empty && dout == $past(dout)))
      else $error("dout moved without a read, dout = %h", dout);

   // read on a truly empty FIFO, any write now lands two edges later
   a_rd_empty: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      $past(idle_rd, 2) |-> ($past(empty) && empty))
      else $error("empty fell too soon after a read on an empty FIFO");

   // ---------------------------------------------------------------------
   // flags
   // ---------------------------------------------------------------------
   // memory never holds more words than the whole FIFO
   a_aempty: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      (empty || held <= AEMPTY_THRESH) |-> aempty)
      else $error("aempty low, empty = %h with %0d words held", empty, held);

   // at most 3 of the words sit outside the memory
   a_afull: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      (full || held >= AFULL_THRESH + 3) |-> afull)
      else $error("afull low, full = %h with %0d words held", full, held);

   // FWFT stage holds at most 3 of the words
   a_aempty_low: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      (held > AEMPTY_THRESH + 3) |-> !aempty)
      else $error("aempty high with %0d words held", held);

endmodule

bind fwft_fifo_top fwft_fifo_sva u_sva (.*);

// File: bench/clk_gen.sv
/*
  clock and reset source for the FIFO testbench
  4 ns clock, reset low for 5 rising edges
  reset released 1 ns after the edge, same point where inputs change
*/

`timescale 1ns/10ps

module clk_gen (
   output logic pos_rclk,
   output logic aresetn_rclk
);

   // free running, half period 2 ns
   initial begin
      pos_rclk = 1'b0;
      forever #2 pos_rclk = ~pos_rclk;
   end

   initial begin
      aresetn_rclk = 1'b0;
      repeat (5) @(posedge pos_rclk);
      #1 aresetn_rclk = 1'b1;
   end

endmodule

// File: rtl/fwft_fifo_top.sv
/*
  single-clock FWFT FIFO top
  full reflects memory words only, up to three more sit in the FWFT stage
  wr_en and rd_en are active-high strobes, no handshake
*/

`timescale 1ns/10ps

module fwft_fifo_top import fwft_fifo_pkg::*; (
   input  logic  pos_rclk,
   input  logic  aresetn_rclk,
   input  logic  wr_en,
   input  data_t din,
   input  logic  rd_en,
   output data_t dout,
   output logic  full,
   output logic  afull,
   output logic  empty,
   output logic  aempty
);

   mem_wr_t    wr;
   mem_rd_t    rd;
   mem_flags_t flags;
   data_t      mem_dout;
   logic       mem_rd_en;

   // pointers, count and memory flags
   fifo_ctrl u_ctrl (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .wr_en        (wr_en),
      .din          (din),
      .mem_rd_en    (mem_rd_en),
      .wr           (wr),
      .rd           (rd),
      .flags        (flags),
      .full         (full),
      .afull        (afull)
   );

   fifo_ram u_ram (
      .pos_rclk (pos_rclk),
      .wr       (wr),
      .rd       (rd),
      .mem_dout (mem_dout)
   );

   // reader side
   fifo_fwft u_fwft (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .flags        (flags),
      .mem_dout     (mem_dout),
      .rd_en        (rd_en),
      .mem_rd_en    (mem_rd_en),
      .dout         (dout),
      .empty        (empty),
      .aempty       (aempty)
   );

endmodule

// File: rtl/fifo_fwft.sv
/*
  first-word-fall-through stage behind the registered-read memory
  three registers: memory output, middle skid and output
  head word sits on dout while empty is low, rd_en pops it
  rd_en is ignored while empty is high
*/

`timescale 1ns/10ps

module fifo_fwft import fwft_fifo_pkg::*; (
   input  logic       pos_rclk,
   input  logic       aresetn_rclk,
   input  mem_flags_t flags,
   input  data_t      mem_dout,
   input  logic       rd_en,
   output logic       mem_rd_en,
   output data_t      dout,
   output logic       empty,
   output logic       aempty
);

   logic  mem_valid;
   logic  mid_valid;
   logic  out_valid;
   data_t mid_dout;
   logic  rd_ack;
   logic  update_dout;
   logic  update_mid;

   // ----------------------------------------------------------------------
   // load decisions
   // ----------------------------------------------------------------------
   assign rd_ack = rd_en & ~empty;

   // output loads when free or being popped
   assign update_dout = (mem_valid | mid_valid) & (rd_ack | ~out_valid);

   // memory word goes to middle when output is busy,
   // or when middle is moving to output this cycle
   assign update_mid = mem_valid & (mid_valid == update_dout);

   // one more read only if some register is free
   assign mem_rd_en = ~flags.empty & ~(mem_valid & mid_valid & out_valid);

   assign aempty = flags.aempty | empty;

   // ----------------------------------------------------------------------
   // valid bits and output register
   // ----------------------------------------------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         mem_valid <= 1'b0;
         mid_valid <= 1'b0;
         out_valid <= 1'b0;
         empty     <= 1'b1;
         dout      <= '0;
      end else begin
         // memory output register valid one edge after the read
         if (mem_rd_en) begin
            mem_valid <= 1'b1;
         end else if (update_mid || update_dout) begin
            mem_valid <= 1'b0;
         end

         if (update_mid) begin
            mid_valid <= 1'b1;
         end else if (update_dout) begin
            mid_valid <= 1'b0;
         end

         if (update_dout) begin
            out_valid <= 1'b1;
            empty     <= 1'b0;
            // middle is older than the memory word
            dout      <= mid_valid ? mid_dout : mem_dout;
         end else if (rd_ack) begin
            out_valid <= 1'b0;
            empty     <= 1'b1;
         end
      end
   end

   // skid register, payload only
   always_ff @(posedge pos_rclk) begin
      if (update_mid) begin
         mid_dout <= mem_dout;
      end
   end

endmodule

// File: rtl/fifo_ram.sv
/*
  register array with one write port and one registered read port
  no read-during-write bypass, the controller never reads the slot
  being written; output holds when no read is enabled
*/

`timescale 1ns/10ps

module fifo_ram import fwft_fifo_pkg::*; (
   input  logic    pos_rclk,
   input  mem_wr_t wr,
   input  mem_rd_t rd,
   output data_t   mem_dout
);

   data_t mem [DEPTH];

   // write port
   always_ff @(posedge pos_rclk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // registered read, output held between reads
   always_ff @(posedge pos_rclk) begin
      if (rd.en) begin
         mem_dout <= mem[rd.addr];
      end
   end

endmodule

// File: rtl/fifo_ctrl.sv
/*
  pointer and flag controller for the FIFO memory
  writes while full are dropped here, reads come only from the FWFT stage
  all flags are registered from the next count value
*/

`timescale 1ns/10ps

module fifo_ctrl import fwft_fifo_pkg::*; (
   input  logic       pos_rclk,
   input  logic       aresetn_rclk,
   input  logic       wr_en,
   input  data_t      din,
   input  logic       mem_rd_en,
   output mem_wr_t    wr,
   output mem_rd_t    rd,
   output mem_flags_t flags,
   output logic       full,
   output logic       afull
);

   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [ADDR_W:0]   count;
   logic [ADDR_W:0]   count_nxt;
   logic              wr_ok;
   logic              rd_ok;

   // ----------------------------------------------------------------------
   // accepted requests
   // ----------------------------------------------------------------------
   assign wr_ok = wr_en & ~full;
   // FWFT already checks empty, kept here so the count cannot underflow
   assign rd_ok = mem_rd_en & ~flags.empty;

   assign wr = '{en: wr_ok, addr: wr_ptr, data: din};
   assign rd = '{en: rd_ok, addr: rd_ptr};

   // next occupancy, unchanged when both happen
   always_comb begin
      count_nxt = count;
      if (wr_ok && !rd_ok) begin
         count_nxt = count + 1'b1;
      end else if (rd_ok && !wr_ok) begin
         count_nxt = count - 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // pointers, count and flags
   // ----------------------------------------------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         full         <= 1'b0;
         afull        <= 1'b0;
         flags.empty  <= 1'b1;
         flags.aempty <= 1'b1;
      end else begin
         // natural wrap at DEPTH
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count        <= count_nxt;
         full         <= (count_nxt == (ADDR_W+1)'(DEPTH));
         afull        <= (count_nxt >= (ADDR_W+1)'(AFULL_THRESH));
         flags.empty  <= (count_nxt == '0);
         flags.aempty <= (count_nxt <= (ADDR_W+1)'(AEMPTY_THRESH));
      end
   end

endmodule

// File: rtl/fwft_fifo_pkg.sv
/*
  shared constants and bus types for the single-clock FWFT FIFO
  DEPTH must be a power of two, the pointers wrap without compare
  thresholds are in memory words and do not count the FWFT registers
*/

package fwft_fifo_pkg;

   localparam int DATA_W        = 16;
   localparam int DEPTH         = 16;
   localparam int ADDR_W        = $clog2(DEPTH);
   localparam int AEMPTY_THRESH = 2;
   localparam int AFULL_THRESH  = DEPTH - 2;

   typedef logic [DATA_W-1:0] data_t;

   // memory write request, controller to RAM
   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      data_t             data;
   } mem_wr_t;

   // memory read request, controller to RAM
   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
   } mem_rd_t;

   // memory side status toward the FWFT stage
   typedef struct packed {
      logic empty;
      logic aempty;
   } mem_flags_t;

endpackage
